// File: bench/coreSerdesTb.sv
`timescale 1ns/1ps
`include "serdes_consts.svh"

module coreSerdesTb import serdesPkg::*; ();

	localparam int waitLimit = 400; // cycles allowed per wait

	logic clk = 1'b0;
	logic rst;
	logic [`WORD_W-1:0] inWord;
	logic inWrite;
	logic inFull;
	logic outRead;
	logic [`WORD_W-1:0] outWord;
	logic outEmpty;

	int mismatchCount;
	int failCount; // timeouts and other failures
	integer seed;
	logic [`ROUTE_W-1:0] routeModel [`ROUTE_ENTRIES]; // expected table contents

	coreSerdes uut (
		.clk      (clk),
		.rst      (rst),
		.inWord   (inWord),
		.inWrite  (inWrite),
		.inFull   (inFull),
		.outRead  (outRead),
		.outWord  (outWord),
		.outEmpty (outEmpty)
	);

	always #4 clk = ~clk; // 8 ns

	// one word into the input fifo once there is room
	task automatic writeWord(input logic [`WORD_W-1:0] w);
		int waited;
		waited = 0;
		@(negedge clk);
		while (inFull && waited < waitLimit) begin
			@(negedge clk);
			waited++;
		end
		if (inFull) begin
			$display("timeout at %0t: input fifo stayed full", $time);
			failCount++;
		end else begin
			@(posedge clk);
			inWord <= w;
			inWrite <= 1'b1;
			@(posedge clk);
			inWrite <= 1'b0;
		end
	endtask

	// four words with low payload first and the flag on the first
	task automatic encodePacket(
		input logic [`CODE_W-1:0] code,
		input logic [`DATA_W-1:0] data
	);
		logic [`IN_PKT_W-1:0] pkt;
		pkt = {code, data};
		writeWord({1'b1, pkt[9:0]});
		writeWord({1'b0, pkt[19:10]});
		writeWord({1'b0, pkt[29:20]});
		writeWord({9'b0, pkt[31:30]}); // two payload bits left
	endtask

	// one word out with q showing up the cycle after the read
	task automatic readWord(output logic [`WORD_W-1:0] w);
		int waited;
		waited = 0;
		w = '0;
		@(negedge clk);
		while (outEmpty && waited < waitLimit) begin
			@(negedge clk);
			waited++;
		end
		if (outEmpty) begin
			$display("timeout at %0t: no word reached the output fifo", $time);
			failCount++;
		end else begin
			@(posedge clk);
			outRead <= 1'b1;
			@(posedge clk);
			outRead <= 1'b0;
			@(negedge clk);
			w = outWord;
		end
	endtask

	// five words back into route, code, data
	task automatic drainPacket(output logic [`OUT_PKT_W-1:0] pkt);
		logic [`WORD_W-1:0] w;
		logic [`OUT_WORDS*`PAYLOAD_W-1:0] slots;
		slots = '0;
		for (int i = 0; i < `OUT_WORDS; i++) begin
			readWord(w);
			if (w[`WORD_W-1] != (i == 0)) begin
				$display("MISMATCH at %0t: start flag %b on word %0d", $time, w[`WORD_W-1], i);
				mismatchCount++;
			end
			slots = {slots[`OUT_WORDS*`PAYLOAD_W-`PAYLOAD_W-1:0], w[`PAYLOAD_W-1:0]};
		end
		if (slots[7:0] != 8'd0) begin
			$display("MISMATCH at %0t: padding bits %h not zero", $time, slots[7:0]);
			mismatchCount++;
		end
		pkt = slots[`OUT_WORDS*`PAYLOAD_W-1 -: `OUT_PKT_W];
	endtask

	task automatic expectPacket(input logic [`OUT_PKT_W-1:0] exp);
		logic [`OUT_PKT_W-1:0] got;
		drainPacket(got);
		if (got !== exp) begin
			$display("MISMATCH at %0t: packet %h, expected %h", $time, got, exp);
			mismatchCount++;
		end
	endtask

	// output fifo must stay empty for n cycles
	task automatic quietOutput(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			if (!outEmpty) begin
				$display("MISMATCH at %0t: unexpected word in output fifo", $time);
				mismatchCount++;
				break;
			end
		end
	endtask

	task automatic loadRoute(input logic [3:0] chan, input logic [`ROUTE_W-1:0] route);
		encodePacket({opSetRoute, chan}, {14'd0, route});
		routeModel[chan] = route; // table updates at acceptance
	endtask

	task automatic resetIdle();
		@(negedge clk);
		if (!outEmpty || inFull) begin
			$display("MISMATCH at %0t: fifo flags wrong after reset", $time);
			mismatchCount++;
		end
		quietOutput(20);
	endtask

	task automatic routedForward();
		loadRoute(4'd3, 10'h2a5);
		quietOutput(40); // setRoute emits nothing
		encodePacket({opForward, 4'd3}, 24'h123456);
		expectPacket({10'h2a5, opForward, 4'd3, 24'h123456});
	endtask

	task automatic broadcastAndUnknown();
		encodePacket({opBroadcast, 4'd5}, 24'hfedcba);
		expectPacket({10'h3ff, opBroadcast, 4'd5, 24'hfedcba});
		encodePacket({4'hc, 4'd3}, 24'h0000ff); // no such opcode
		quietOutput(60);
		encodePacket({opForward, 4'd3}, 24'h5a5a5a);
		expectPacket({routeModel[3], opForward, 4'd3, 24'h5a5a5a});
	endtask

	// half a packet followed by a fresh start word
	task automatic truncatedPacket();
		logic [`IN_PKT_W-1:0] lost;
		lost = {opForward, 4'd3, 24'h0badad};
		writeWord({1'b1, lost[9:0]});
		writeWord({1'b0, lost[19:10]});
		encodePacket({opForward, 4'd3}, 24'h600d42);
		expectPacket({routeModel[3], opForward, 4'd3, 24'h600d42});
		quietOutput(60);
	endtask

	// fill the whole pipe without reading and drain in order
	task automatic backPressure();
		logic [`OUT_PKT_W-1:0] expQ [$];
		logic [31:0] r;
		logic [3:0] chan;
		logic [`DATA_W-1:0] data;
		int sent;
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			loadRoute(4'(i), r[9:0]);
		end
		sent = 0;
		while (!inFull && sent < 12) begin
			r = $random(seed);
			chan = {2'b00, r[1:0]}; // channels with fresh routes
			r = $random(seed);
			data = r[`DATA_W-1:0];
			encodePacket({opForward, chan}, data);
			expQ.push_back({routeModel[chan], opForward, chan, data});
			sent++;
			@(negedge clk);
		end
		if (!inFull || sent < 8) begin
			$display("input fifo did not fill as expected, %0d packets sent", sent);
			failCount++;
		end
		while (expQ.size() > 0)
			expectPacket(expQ.pop_front());
	endtask

	// later forwards see the new route, earlier ones the old
	task automatic routeOverwrite();
		logic [`OUT_PKT_W-1:0] first;
		loadRoute(4'd7, 10'h155);
		encodePacket({opForward, 4'd7}, 24'habcdef);
		first = {routeModel[7], opForward, 4'd7, 24'habcdef};
		loadRoute(4'd7, 10'h0ca);
		encodePacket({opForward, 4'd7}, 24'h13579b);
		expectPacket(first);
		expectPacket({10'h0ca, opForward, 4'd7, 24'h13579b});
	endtask

	initial begin
		seed = 32'h2c03;
		mismatchCount = 0;
		failCount = 0;
		for (int i = 0; i < `ROUTE_ENTRIES; i++)
			routeModel[i] = '0; // reset clears the table
		rst = 1'b1;
		inWord = '0;
		inWrite = 1'b0;
		outRead = 1'b0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		resetIdle();
		routedForward();
		broadcastAndUnknown();
		truncatedPacket();
		backPressure();
		routeOverwrite();
		$display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: bench/coreSerdes_properties.sv
`timescale 1ns/1ps
`include "serdes_consts.svh"

module coreSerdesProperties (
	input logic                 clk,
	input logic                 rst,
	input logic                 inWrite,
	input logic                 inFull,
	input logic                 outRead,
	input logic                 outEmpty,
	input logic                 pktValid,
	input logic                 pktReady,
	input logic [`IN_PKT_W-1:0] pktData,
	input logic                 rtValid,
	input logic                 rtReady
);

	// fifo strobes from the outside world
	inNoOverflow: assert property (@(posedge clk) disable iff (rst) inWrite |-> !inFull)
		else $error("write into full input fifo");
	outNoUnderflow: assert property (@(posedge clk) disable iff (rst) outRead |-> !outEmpty)
		else $error("read from empty output fifo");

	// valid/ready held until the transfer
	pktHeld: assert property (@(posedge clk) disable iff (rst)
		pktValid && !pktReady |=> pktValid && $stable(pktData))
		else $error("deserializer packet changed before transfer");
	rtHeld: assert property (@(posedge clk) disable iff (rst)
		rtValid && !rtReady |=> rtValid)
		else $error("core dropped rtValid before transfer");

endmodule

bind coreSerdes coreSerdesProperties props (
	.clk        (clk),
	.rst        (rst),
	.inWrite    (inWrite),
	.inFull     (inFull),
	.outRead    (outRead),
	.outEmpty   (outEmpty),
	.pktValid   (pktValid),
	.pktReady   (pktReady),
	.pktData    (pktData),
	.rtValid    (rtValid),
	.rtReady    (rtReady)
);

// File: build.f
+incdir+include
logic/serdesPkg.sv
logic/wordFifo.sv
logic/packetDeserializer.sv
logic/packetCore.sv
logic/packetSerializer.sv
logic/coreSerdes.sv
bench/coreSerdes_properties.sv
bench/coreSerdesTb.sv

// File: include/serdes_consts.svh
`ifndef SERDES_CONSTS_SVH
`define SERDES_CONSTS_SVH

// fifo word is start flag plus payload
`define WORD_W 11
`define PAYLOAD_W 10

// packet fields
`define CODE_W 8
`define DATA_W 24
`define ROUTE_W 10

// inbound packet is code then data
`define IN_PKT_W 32
// outbound adds the route on top
`define OUT_PKT_W 42

`define IN_WORDS 4 // last one only carries two payload bits
`define OUT_WORDS 5 // 50 bits of slots for 42 bits

`define ROUTE_ENTRIES 16 // one per channel index
`define FIFO_DEPTH 16

`endif

// File: logic/coreSerdes.sv
`timescale 1ns/1ps
`include "serdes_consts.svh"

module coreSerdes (
	input  logic               clk,
	input  logic               rst,
	input  logic [`WORD_W-1:0] inWord,
	input  logic               inWrite,
	output logic               inFull,
	input  logic               outRead,
	output logic [`WORD_W-1:0] outWord,
	output logic               outEmpty
);

	// input fifo to deserializer
	logic inEmpty;
	logic [`WORD_W-1:0] inQ;
	logic deserRdreq;

	// deserializer to core
	logic pktValid;
	logic pktReady;
	logic [`IN_PKT_W-1:0] pktData;

	// core to serializer
	logic rtValid;
	logic rtReady;
	logic [`OUT_PKT_W-1:0] rtData;

	// serializer to output fifo
	logic serWrreq;
	logic [`WORD_W-1:0] serWord;
	logic outFull;

	wordFifo #(.depth(`FIFO_DEPTH)) inFifo (
		.clk   (clk),
		.rst   (rst),
		.data  (inWord),
		.wrreq (inWrite),
		.rdreq (deserRdreq),
		.q     (inQ),
		.full  (inFull),
		.empty (inEmpty)
	);

	packetDeserializer deser (
		.clk       (clk),
		.rst       (rst),
		.fifoEmpty (inEmpty),
		.fifoWord  (inQ),
		.rdreq     (deserRdreq),
		.pktValid  (pktValid),
		.pktData   (pktData),
		.pktReady  (pktReady)
	);

	packetCore core (
		.clk      (clk),
		.rst      (rst),
		.pktValid (pktValid),
		.pktData  (pktData),
		.pktReady (pktReady),
		.rtValid  (rtValid),
		.rtData   (rtData),
		.rtReady  (rtReady)
	);

	packetSerializer ser (
		.clk      (clk),
		.rst      (rst),
		.rtValid  (rtValid),
		.rtData   (rtData),
		.rtReady  (rtReady),
		.fifoFull (outFull),
		.wrreq    (serWrreq),
		.fifoWord (serWord)
	);

	wordFifo #(.depth(`FIFO_DEPTH)) outFifo (
		.clk   (clk),
		.rst   (rst),
		.data  (serWord),
		.wrreq (serWrreq),
		.rdreq (outRead), // outWord valid the cycle after
		.q     (outWord),
		.full  (outFull),
		.empty (outEmpty)
	);

endmodule

// File: logic/packetCore.sv
`timescale 1ns/1ps
`include "serdes_consts.svh"

module packetCore import serdesPkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  pktValid,
	input  logic [`IN_PKT_W-1:0]  pktData,
	output logic                  pktReady,
	output logic                  rtValid,
	output logic [`OUT_PKT_W-1:0] rtData,
	input  logic                  rtReady
);

	localparam int chanW = $clog2(`ROUTE_ENTRIES);

	logic [`CODE_W-1:0] code;
	logic [`DATA_W-1:0] data;
	opcode_t opcode;
	logic [chanW-1:0] chan;
	logic [`ROUTE_W-1:0] routeTable [`ROUTE_ENTRIES];
	logic [`ROUTE_W-1:0] routeSel;
	logic accept;
	logic emits; // opcode produces an output packet

	// code byte on top, then data
	assign code = pktData[`IN_PKT_W-1 -: `CODE_W];
	assign data = pktData[`DATA_W-1:0];
	assign opcode = opcode_t'(code[`CODE_W-1 -: 4]);
	assign chan = code[chanW-1:0];

	// free slot or slot draining this cycle
	assign pktReady = !rtValid || rtReady;
	assign accept = pktValid && pktReady;

	assign emits = (opcode == opForward) || (opcode == opBroadcast);
	assign routeSel = (opcode == opBroadcast) ? '1 : routeTable[chan];

	always_ff @(posedge clk) begin
		if (rst) begin
			rtValid <= 1'b0;
			for (int i = 0; i < `ROUTE_ENTRIES; i++)
				routeTable[i] <= '0;
		end else begin
			if (accept) begin
				rtValid <= emits; // unknown ops and setRoute leave nothing
				case (opcode)
					opSetRoute: routeTable[chan] <= data[`ROUTE_W-1:0];
					default: ; // table untouched
				endcase
			end else if (rtReady) begin
				rtValid <= 1'b0; // serializer took it
			end
		end
	end

	// route in top bits, then code, then data
	always_ff @(posedge clk) begin
		if (accept && emits)
			rtData <= {routeSel, code, data};
	end

endmodule

// File: logic/packetDeserializer.sv
`timescale 1ns/1ps
`include "serdes_consts.svh"

module packetDeserializer import serdesPkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 fifoEmpty,
	input  logic [`WORD_W-1:0]   fifoWord,
	output logic                 rdreq,
	output logic                 pktValid,
	output logic [`IN_PKT_W-1:0] pktData,
	input  logic                 pktReady
);

	localparam int asmW = `IN_WORDS * `PAYLOAD_W; // 40 bits of word slots
	localparam int idxW = $clog2(`IN_WORDS);

	deserState_t state;
	logic [idxW-1:0] wordIdx; // next slot to fill
	logic pending; // q valid this cycle
	logic startFlag;
	logic [`PAYLOAD_W-1:0] payload;
	logic [asmW-1:0] asmReg; // shift in from the top, lsb word first

	assign startFlag = fifoWord[`WORD_W-1];
	assign payload = fifoWord[`PAYLOAD_W-1:0];

	// one read outstanding at a time, never while holding
	assign rdreq = !fifoEmpty && !pending && (state != deserHold);

	assign pktValid = (state == deserHold);
	assign pktData = asmReg[`IN_PKT_W-1:0]; // top bits of last word are padding

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= deserIdle;
			wordIdx <= '0;
			pending <= 1'b0;
		end else begin
			pending <= rdreq;
			if (pending) begin
				if (startFlag) begin
					// start word always restarts, truncated packet lost
					state <= deserAssemble;
					wordIdx <= idxW'(1);
				end else if (state == deserAssemble) begin
					if (wordIdx == idxW'(`IN_WORDS - 1)) begin
						state <= deserHold; // all four in
						wordIdx <= '0;
					end else begin
						wordIdx <= wordIdx + 1'b1;
					end
				end
				// no flag at index 0 just falls through and is dropped
			end else if (state == deserHold && pktReady) begin
				state <= deserIdle; // core took it
			end
		end
	end

	// payload path
	always_ff @(posedge clk) begin
		if (pending && (startFlag || state == deserAssemble))
			asmReg <= {payload, asmReg[asmW-1:`PAYLOAD_W]};
	end

endmodule

// File: logic/packetSerializer.sv
`timescale 1ns/1ps
`include "serdes_consts.svh"

module packetSerializer import serdesPkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  rtValid,
	input  logic [`OUT_PKT_W-1:0] rtData,
	output logic                  rtReady,
	input  logic                  fifoFull,
	output logic                  wrreq,
	output logic [`WORD_W-1:0]    fifoWord
);

	localparam int slotW = `OUT_WORDS * `PAYLOAD_W; // 50
	localparam int padW = slotW - `OUT_PKT_W; // zeros at the low end
	localparam int cntW = $clog2(`OUT_WORDS);

	serState_t state;
	logic [slotW-1:0] shiftReg; // next slice always in the top bits
	logic [cntW-1:0] wordCnt; // words pushed so far
	logic accept;

	assign rtReady = (state == serIdle);
	assign accept = rtValid && rtReady;

	// stall while the output fifo is full
	assign wrreq = (state == serSend) && !fifoFull;
	assign fifoWord = {wordCnt == '0, shiftReg[slotW-1 -: `PAYLOAD_W]}; // flag on word 0

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= serIdle;
			wordCnt <= '0;
		end else begin
			case (state)
				serIdle: begin
					if (accept) begin
						state <= serSend;
						wordCnt <= '0;
					end
				end
				serSend: begin
					if (wrreq) begin
						if (wordCnt == cntW'(`OUT_WORDS - 1)) begin
							state <= serIdle; // fifth word out
							wordCnt <= '0;
						end else begin
							wordCnt <= wordCnt + 1'b1;
						end
					end
				end
				default: state <= serIdle;
			endcase
		end
	end

	// latch and shift the packet
	always_ff @(posedge clk) begin
		if (accept)
			shiftReg <= {rtData, {padW{1'b0}}};
		else if (wrreq)
			shiftReg <= shiftReg << `PAYLOAD_W;
	end

endmodule

// File: logic/serdesPkg.sv
package serdesPkg;

	// high nibble of the code byte
	typedef enum logic [3:0] {
		opSetRoute  = 4'd1, // load route for the channel
		opForward   = 4'd2, // emit with table route
		opBroadcast = 4'd3  // emit with route all ones
	} opcode_t;

	// deserializer
	typedef enum logic [1:0] {
		deserIdle,     // waiting for a start word
		deserAssemble, // collecting the rest
		deserHold      // packet complete, waiting on the core
	} deserState_t;

	// serializer
	typedef enum logic {
		serIdle, // ready for a packet
		serSend  // pushing words out
	} serState_t;

endpackage

// File: logic/wordFifo.sv
`timescale 1ns/1ps
`include "serdes_consts.svh"

module wordFifo #(
	parameter int depth = `FIFO_DEPTH
) (
	input  logic               clk,
	input  logic               rst,
	input  logic [`WORD_W-1:0] data,
	input  logic               wrreq,
	input  logic               rdreq,
	output logic [`WORD_W-1:0] q,
	output logic               full,
	output logic               empty
);

	localparam int ptrW = $clog2(depth);
	localparam int cntW = $clog2(depth + 1);

	logic [`WORD_W-1:0] mem [depth]; // storage, no reset
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] count; // words held
	logic doWrite;
	logic doRead;

	// drop writes when full and reads when empty
	assign doWrite = wrreq && !full;
	assign doRead = rdreq && !empty;

	assign full = (count == cntW'(depth));
	assign empty = (count == '0);

	// pointers wrap at depth
	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doWrite)
				wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
			if (doRead)
				rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
			case ({doWrite, doRead})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (doWrite)
			mem[wrPtr] <= data;
		if (doRead)
			q <= mem[rdPtr]; // shows up the cycle after rdreq
	end

endmodule

// File: run.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module coreSerdesTb -f build.f &&
./obj_dir/VcoreSerdesTb | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
